//--- hw/tmr_config.svh
// Build-time sizes and reset mode of the lockstep group, included by every file that needs them

`ifndef TMR_CONFIG_SVH
`define TMR_CONFIG_SVH

// Width of the data word each core presents to the voter
`define TMR_DATA_W 32

// Number of state words moved per unload and per reload
`define TMR_STATE_DEPTH 4

// Width of each saturating mismatch counter
`define TMR_CNT_W 8

// Set to 1 to leave reset with lockstep enabled
`define TMR_DEFAULT_ON 0

`endif

//--- hw/tmr_pkg.sv
// Shared types and register map of the lockstep group, referenced by scoped names

`default_nettype none

package tmr_pkg;

  // Operating mode of the group
  typedef enum logic [1:0] {
    NON_TMR    = 2'd0,
    TMR_RUN    = 2'd1,
    TMR_UNLOAD = 2'd2,
    TMR_RELOAD = 2'd3
  } tmr_mode_e;

  // Configuration register, setback sits in bit 0
  typedef struct packed {
    logic [27:0] reserved;
    logic        force_resynch;
    logic        synch_req;
    logic        reload_setback;
    logic        setback;
  } tmr_cfg_t;

  // One register word, seen as config fields or as a raw clear mask
  typedef union packed {
    tmr_cfg_t    cfg;
    logic [31:0] raw;
  } tmr_reg_word_u;

  // Register addresses
  localparam logic [3:0] TMR_ADDR_ENABLE = 4'd0;
  localparam logic [3:0] TMR_ADDR_CONFIG = 4'd1;
  localparam logic [3:0] TMR_ADDR_CLEAR  = 4'd2;
  localparam logic [3:0] TMR_ADDR_CNT0   = 4'd3;
  localparam logic [3:0] TMR_ADDR_CNT1   = 4'd4;
  localparam logic [3:0] TMR_ADDR_CNT2   = 4'd5;

endpackage

`default_nettype wire

//--- hw/tmr_regs.sv
// Software register file of the lockstep group, answering each bus request one cycle later

`include "tmr_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tmr_regs (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        reg_valid_i,
  input  wire logic        reg_write_i,
  input  wire logic [3:0]  reg_addr_i,
  input  wire logic [31:0] reg_wdata_i,
  output logic             reg_rvalid_o,
  output logic [31:0]      reg_rdata_o,
  input  wire logic [2:0]  incr_mismatch_i,
  input  wire logic        force_clear_i,
  output logic             tmr_enable_o,
  output tmr_pkg::tmr_cfg_t cfg_o,
  output logic             force_resynch_o
);

  localparam int unsigned cnt_w = `TMR_CNT_W;

  tmr_pkg::tmr_reg_word_u wr_word;
  tmr_pkg::tmr_reg_word_u rd_word;
  tmr_pkg::tmr_cfg_t      cfg_wr;
  tmr_pkg::tmr_cfg_t      cfg_q;
  logic                   enable_q;
  logic [2:0][cnt_w-1:0]  cnt_q;
  logic                   wr_en;
  logic                   rd_en;
  logic [2:0]             clr_mask;

  assign wr_word.raw = reg_wdata_i;
  assign wr_en       = reg_valid_i & reg_write_i;
  assign rd_en       = reg_valid_i & ~reg_write_i;

  // Reserved bits never stick
  always_comb begin
    cfg_wr          = wr_word.cfg;
    cfg_wr.reserved = '0;
  end

  assign clr_mask = (wr_en && reg_addr_i == tmr_pkg::TMR_ADDR_CLEAR) ? wr_word.raw[2:0] : 3'b000;

  assign tmr_enable_o    = enable_q;
  assign cfg_o           = cfg_q;
  assign force_resynch_o = cfg_q.force_resynch;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= (`TMR_DEFAULT_ON != 0);
      cfg_q    <= '0;
    end else begin
      // Controller acknowledges the forced resynch
      if (force_clear_i) begin
        cfg_q.force_resynch <= 1'b0;
      end
      if (wr_en && reg_addr_i == tmr_pkg::TMR_ADDR_ENABLE) begin
        enable_q <= wr_word.raw[0];
      end
      if (wr_en && reg_addr_i == tmr_pkg::TMR_ADDR_CONFIG) begin
        cfg_q <= cfg_wr;
      end
    end
  end

  // Saturating counters, a clear beats a same-cycle increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (clr_mask[i]) begin
          cnt_q[i] <= '0;
        end else if (incr_mismatch_i[i] && cnt_q[i] != {cnt_w{1'b1}}) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    rd_word.raw = '0;
    case (reg_addr_i)
      tmr_pkg::TMR_ADDR_ENABLE: rd_word.raw[0] = enable_q;
      tmr_pkg::TMR_ADDR_CONFIG: rd_word.cfg = cfg_q;
      tmr_pkg::TMR_ADDR_CNT0:   rd_word.raw[cnt_w-1:0] = cnt_q[0];
      tmr_pkg::TMR_ADDR_CNT1:   rd_word.raw[cnt_w-1:0] = cnt_q[1];
      tmr_pkg::TMR_ADDR_CNT2:   rd_word.raw[cnt_w-1:0] = cnt_q[2];
      default:                  rd_word.raw = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= reg_valid_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    reg_rdata_o <= rd_en ? rd_word.raw : 32'h0;
  end

endmodule

`default_nettype wire

//--- hw/tmr_vote.sv
// Combinational majority voter over the three core data words, flags the disagreeing core

`include "tmr_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tmr_vote (
  input  wire logic [2:0][`TMR_DATA_W-1:0] core_data_i,
  output logic [`TMR_DATA_W-1:0]           voted_data_o,
  output logic [2:0]                       tmr_error_o,
  output logic                             single_mismatch_o,
  output logic                             failure_o
);

  logic eq_01;
  logic eq_02;
  logic eq_12;
  logic all_eq;
  logic any_eq;

  // Bitwise majority
  assign voted_data_o = (core_data_i[0] & core_data_i[1]) |
                        (core_data_i[0] & core_data_i[2]) |
                        (core_data_i[1] & core_data_i[2]);

  // Each core against the voted word
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      tmr_error_o[i] = (core_data_i[i] != voted_data_o);
    end
  end

  // Pairwise equality
  assign eq_01 = (core_data_i[0] == core_data_i[1]);
  assign eq_02 = (core_data_i[0] == core_data_i[2]);
  assign eq_12 = (core_data_i[1] == core_data_i[2]);

  assign all_eq = eq_01 & eq_02 & eq_12;
  assign any_eq = eq_01 | eq_02 | eq_12;

  // Exactly one matching pair means one odd core out
  assign single_mismatch_o = any_eq & ~all_eq;

  // No pair agrees, nothing to vote on
  assign failure_o = ~any_eq;

endmodule

`default_nettype wire

//--- hw/tmr_ctrl.sv
// Lockstep mode FSM, reacts to mismatches with unload, setback and reload of the core state

`include "tmr_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tmr_ctrl (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              tmr_enable_i,
  input  wire tmr_pkg::tmr_cfg_t cfg_i,
  input  wire logic              force_resynch_i,
  input  wire logic              single_mismatch_i,
  input  wire logic              failure_i,
  input  wire logic [2:0]        tmr_error_i,
  input  wire logic              store_full_i,
  input  wire logic              store_empty_i,
  input  wire logic              fetch_en_i,
  input  wire logic              cores_synch_i,
  output tmr_pkg::tmr_mode_e     mode_o,
  output logic [2:0]             setback_o,
  output logic                   unload_en_o,
  output logic                   reload_en_o,
  output logic [2:0]             incr_mismatch_o,
  output logic                   force_clear_o,
  output logic                   sw_resynch_req_o,
  output logic                   sw_synch_req_o
);

  localparam tmr_pkg::tmr_mode_e default_mode =
    (`TMR_DEFAULT_ON != 0) ? tmr_pkg::TMR_RUN : tmr_pkg::NON_TMR;

  tmr_pkg::tmr_mode_e mode_d;
  tmr_pkg::tmr_mode_e mode_q;
  logic               cores_synch_q;
  logic               synch_req;
  logic               synch_req_q;
  logic               resynch_req;
  logic               resynch_req_q;

  assign mode_o      = mode_q;
  assign unload_en_o = (mode_q == tmr_pkg::TMR_UNLOAD);
  assign reload_en_o = (mode_q == tmr_pkg::TMR_RELOAD);
  assign resynch_req = unload_en_o;

  // Requests leave as single-cycle pulses on their rising edge
  assign sw_resynch_req_o = resynch_req & ~resynch_req_q;
  assign sw_synch_req_o   = synch_req & ~synch_req_q;

  always_comb begin
    mode_d          = mode_q;
    setback_o       = 3'b000;
    incr_mismatch_o = 3'b000;
    force_clear_o   = 1'b0;
    synch_req       = 1'b0;

    case (mode_q)
      tmr_pkg::TMR_RUN: begin
        if (force_resynch_i) begin
          force_clear_o = 1'b1;
          mode_d        = tmr_pkg::TMR_UNLOAD;
        end
        // Count the offending core and start recovery
        if (single_mismatch_i) begin
          incr_mismatch_o = tmr_error_i;
          mode_d          = tmr_pkg::TMR_UNLOAD;
        end
      end

      tmr_pkg::TMR_UNLOAD: begin
        // State saved, reset cores once and restore
        if (store_full_i) begin
          mode_d = tmr_pkg::TMR_RELOAD;
          if (cfg_i.setback) begin
            setback_o = 3'b111;
          end
        end
      end

      tmr_pkg::TMR_RELOAD: begin
        if (store_empty_i) begin
          mode_d = tmr_pkg::TMR_RUN;
        end else if ((single_mismatch_i || failure_i) && cfg_i.reload_setback) begin
          // Fresh error while restoring
          setback_o = 3'b111;
        end
      end

      tmr_pkg::NON_TMR: begin
        // Wait for software to bring the cores in step
        if (tmr_enable_i) begin
          synch_req = cfg_i.synch_req;
          if (cores_synch_q) begin
            mode_d = tmr_pkg::TMR_RELOAD;
          end
        end
      end

      default: begin
        mode_d = tmr_pkg::NON_TMR;
      end
    endcase

    // Before fetch starts the mode simply tracks the enable bit
    if (!fetch_en_i) begin
      synch_req = 1'b0;
      mode_d    = tmr_enable_i ? tmr_pkg::TMR_RUN : tmr_pkg::NON_TMR;
    end

    // Leaving lockstep, cores 1 and 2 restart
    if (mode_q == tmr_pkg::TMR_RUN && !tmr_enable_i) begin
      mode_d = tmr_pkg::NON_TMR;
      if (cfg_i.setback) begin
        setback_o = 3'b110;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q        <= default_mode;
      cores_synch_q <= 1'b0;
      synch_req_q   <= 1'b0;
      resynch_req_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      cores_synch_q <= cores_synch_i;
      synch_req_q   <= synch_req;
      resynch_req_q <= resynch_req;
    end
  end

endmodule

`default_nettype wire

//--- hw/tmr_state_store.sv
// Pointer model of the core state store, filled during unload and drained during reload

`include "tmr_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tmr_state_store (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic unload_en_i,
  input  wire logic reload_en_i,
  output logic      store_full_o,
  output logic      store_empty_o
);

  localparam int unsigned depth = `TMR_STATE_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] ptr_max = ptr_w'(depth);

  logic [ptr_w-1:0] ptr_d;
  logic [ptr_w-1:0] ptr_q;
  logic             full_q;
  logic             empty_q;

  // One word per cycle in either direction
  always_comb begin
    ptr_d = ptr_q;
    if (unload_en_i && !full_q) begin
      ptr_d = ptr_q + 1'b1;
    end else if (reload_en_i && !empty_q) begin
      ptr_d = ptr_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q   <= '0;
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else begin
      ptr_q   <= ptr_d;
      // Flags follow the new pointer
      full_q  <= (ptr_d == ptr_max);
      empty_q <= (ptr_d == '0);
    end
  end

  assign store_full_o  = full_q;
  assign store_empty_o = empty_q;

endmodule

`default_nettype wire

//--- hw/tmr_top.sv
// Top level of the lockstep control subsystem, joins registers, voter, FSM and state store

`include "tmr_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tmr_top (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        reg_valid_i,
  input  wire logic                        reg_write_i,
  input  wire logic [3:0]                  reg_addr_i,
  input  wire logic [31:0]                 reg_wdata_i,
  output logic                             reg_rvalid_o,
  output logic [31:0]                      reg_rdata_o,
  input  wire logic [2:0][`TMR_DATA_W-1:0] core_data_i,
  output logic [`TMR_DATA_W-1:0]           voted_data_o,
  input  wire logic                        fetch_en_i,
  input  wire logic                        cores_synch_i,
  output tmr_pkg::tmr_mode_e               mode_o,
  output logic [2:0]                       setback_o,
  output logic                             sw_resynch_req_o,
  output logic                             sw_synch_req_o
);

  logic              tmr_enable;
  tmr_pkg::tmr_cfg_t cfg;
  logic              force_resynch;
  logic              force_clear;
  logic [2:0]        incr_mismatch;
  logic [2:0]        tmr_error;
  logic              single_mismatch;
  logic              failure;
  logic              unload_en;
  logic              reload_en;
  logic              store_full;
  logic              store_empty;

  tmr_regs u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reg_valid_i     (reg_valid_i),
    .reg_write_i     (reg_write_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rvalid_o    (reg_rvalid_o),
    .reg_rdata_o     (reg_rdata_o),
    .incr_mismatch_i (incr_mismatch),
    .force_clear_i   (force_clear),
    .tmr_enable_o    (tmr_enable),
    .cfg_o           (cfg),
    .force_resynch_o (force_resynch)
  );

  tmr_vote u_vote (
    .core_data_i       (core_data_i),
    .voted_data_o      (voted_data_o),
    .tmr_error_o       (tmr_error),
    .single_mismatch_o (single_mismatch),
    .failure_o         (failure)
  );

  tmr_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .tmr_enable_i      (tmr_enable),
    .cfg_i             (cfg),
    .force_resynch_i   (force_resynch),
    .single_mismatch_i (single_mismatch),
    .failure_i         (failure),
    .tmr_error_i       (tmr_error),
    .store_full_i      (store_full),
    .store_empty_i     (store_empty),
    .fetch_en_i        (fetch_en_i),
    .cores_synch_i     (cores_synch_i),
    .mode_o            (mode_o),
    .setback_o         (setback_o),
    .unload_en_o       (unload_en),
    .reload_en_o       (reload_en),
    .incr_mismatch_o   (incr_mismatch),
    .force_clear_o     (force_clear),
    .sw_resynch_req_o  (sw_resynch_req_o),
    .sw_synch_req_o    (sw_synch_req_o)
  );

  tmr_state_store u_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .unload_en_i   (unload_en),
    .reload_en_i   (reload_en),
    .store_full_o  (store_full),
    .store_empty_o (store_empty)
  );

endmodule

`default_nettype wire

//--- test/tmr_props.sv
// Concurrent checks on the lockstep FSM outputs, bound into tmr_ctrl from the testbench

`timescale 1ns/1ps
`default_nettype none

module tmr_props (
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire logic [2:0] setback_i,
  input wire logic       unload_en_i,
  input wire logic       reload_en_i,
  input wire logic       sw_resynch_req_i,
  input wire logic       sw_synch_req_i
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // Full setback, cores 1 and 2 only, or none
  a_setback_codes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    setback_i inside {3'b000, 3'b110, 3'b111})
    else begin
      fail_count++;
      $error("setback code %b is not 000, 110 or 111", setback_i);
    end

  a_store_dir: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(unload_en_i && reload_en_i))
    else begin
      fail_count++;
      $error("unload and reload enabled together");
    end

  // Requests are edge pulses
  a_resynch_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_resynch_req_i |=> !sw_resynch_req_i)
    else begin
      fail_count++;
      $error("resynch request held for two cycles");
    end

  a_synch_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_synch_req_i |=> !sw_synch_req_i)
    else begin
      fail_count++;
      $error("synch request held for two cycles");
    end

endmodule

`default_nettype wire

//--- test/tmr_tb.sv
// Testbench for the lockstep control top level, run through compile.f and run.sh

`include "tmr_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tmr_tb;

  localparam int data_w  = `TMR_DATA_W;
  localparam int depth   = `TMR_STATE_DEPTH;
  localparam int cnt_max = (1 << `TMR_CNT_W) - 1;
  // The tests need about 250 cycles
  localparam int max_cycles = 2000;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   reg_valid;
  logic                   reg_we;
  logic [3:0]             reg_addr;
  logic [31:0]            reg_wdata;
  logic                   reg_rvalid;
  logic [31:0]            reg_rdata;
  logic [2:0][data_w-1:0] core_data;
  logic [data_w-1:0]      voted_data;
  logic                   fetch_en;
  logic                   cores_synch;
  tmr_pkg::tmr_mode_e     mode;
  logic [2:0]             setback;
  logic                   sw_resynch_req;
  logic                   sw_synch_req;

  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int test_start_errors = 0;
  int prop_fails;
  int cnt_model [3];

  // Counts gathered by the monitor and cleared by the stimulus
  int unload_cycles;
  int reload_cycles;
  int sb_full;
  int sb_partial;
  int resynch_pulses;
  int synch_pulses;

  tmr_top uut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .reg_valid_i      (reg_valid),
    .reg_write_i      (reg_we),
    .reg_addr_i       (reg_addr),
    .reg_wdata_i      (reg_wdata),
    .reg_rvalid_o     (reg_rvalid),
    .reg_rdata_o      (reg_rdata),
    .core_data_i      (core_data),
    .voted_data_o     (voted_data),
    .fetch_en_i       (fetch_en),
    .cores_synch_i    (cores_synch),
    .mode_o           (mode),
    .setback_o        (setback),
    .sw_resynch_req_o (sw_resynch_req),
    .sw_synch_req_o   (sw_synch_req)
  );

  bind tmr_ctrl tmr_props u_props (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .setback_i        (setback_o),
    .unload_en_i      (unload_en_o),
    .reload_en_i      (reload_en_o),
    .sw_resynch_req_i (sw_resynch_req_o),
    .sw_synch_req_i   (sw_synch_req_o)
  );

  initial begin
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run went past the limit of %0d clock cycles", max_cycles);
      $display("tests failed");
      $finish;
    end
  end

  // Values read at the clock edge belong to the cycle that just ended
  always @(posedge clk) begin
    if (rst_n) begin
      if (mode == tmr_pkg::TMR_UNLOAD) begin
        unload_cycles++;
      end
      if (mode == tmr_pkg::TMR_RELOAD) begin
        reload_cycles++;
      end
      if (setback == 3'b111) begin
        sb_full++;
      end
      if (setback == 3'b110) begin
        sb_partial++;
      end
      if (sw_resynch_req) begin
        resynch_pulses++;
      end
      if (sw_synch_req) begin
        synch_pulses++;
      end
    end
  end

  // Per-bit majority
  // A core is in error when its word differs from the majority
  function automatic logic [data_w-1:0] ref_vote(input logic [2:0][data_w-1:0] d,
                                                 output logic [2:0] err);
    logic [data_w-1:0] maj;
    int                ones;
    for (int b = 0; b < data_w; b++) begin
      ones   = int'(d[0][b]) + int'(d[1][b]) + int'(d[2][b]);
      maj[b] = (ones >= 2);
    end
    for (int c = 0; c < 3; c++) begin
      err[c] = (d[c] != maj);
    end
    return maj;
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_start_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  task automatic clear_monitor();
    unload_cycles  = 0;
    reload_cycles  = 0;
    sb_full        = 0;
    sb_partial     = 0;
    resynch_pulses = 0;
    synch_pulses   = 0;
  endtask

  // Writes are answered with rvalid and zero data one cycle later
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_we    = 1'b0;
    check_val("write response valid", 32'd1, 32'(reg_rvalid));
    check_val("write response data", 32'd0, reg_rdata);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = addr;
    @(negedge clk);
    reg_valid = 1'b0;
    check_val("read response valid", 32'd1, 32'(reg_rvalid));
    data = reg_rdata;
  endtask

  task automatic read_counters(input string name);
    logic [31:0] val;
    for (int i = 0; i < 3; i++) begin
      read_reg(tmr_pkg::TMR_ADDR_CNT0 + 4'(i), val);
      check_val(name, 32'(cnt_model[i]), val);
    end
  endtask

  task automatic wait_mode(input string name, input tmr_pkg::tmr_mode_e target);
    int waited;
    waited = 0;
    while (mode != target && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    if (mode != target) begin
      errors++;
      $display("%s: mode %0d was not reached within 40 cycles", name, target);
    end
  endtask

  // One core disagrees for a single cycle while the group runs in lockstep
  task automatic inject_mismatch(input int core, input logic [data_w-1:0] good);
    @(negedge clk);
    core_data[core] = ~good;
    @(negedge clk);
    core_data[core] = good;
    if (cnt_model[core] < cnt_max) begin
      cnt_model[core]++;
    end
    wait_mode("mismatch unload", tmr_pkg::TMR_UNLOAD);
    wait_mode("mismatch return", tmr_pkg::TMR_RUN);
  endtask

  task automatic check_recovery(input string name);
    check_val({name, " unload cycles"}, 32'(depth + 1), 32'(unload_cycles));
    check_val({name, " reload cycles"}, 32'(depth + 1), 32'(reload_cycles));
    check_val({name, " setback 111"}, 32'd1, 32'(sb_full));
    check_val({name, " resynch pulses"}, 32'd1, 32'(resynch_pulses));
    check_val({name, " final mode"}, 32'(tmr_pkg::TMR_RUN), 32'(mode));
  endtask

  initial begin
    logic [data_w-1:0]      base;
    logic [data_w-1:0]      good;
    logic [data_w-1:0]      exp_word;
    logic [2:0]             exp_err;
    logic [2:0][data_w-1:0] trip;
    logic [31:0]            val;
    int                     pick;
    tmr_pkg::tmr_reg_word_u word;

    void'($urandom(95));
    good        = 32'hA5C3_0F96;
    reg_valid   = 1'b0;
    reg_we      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    core_data   = {good, good, good};
    fetch_en    = 1'b0;
    cores_synch = 1'b0;
    for (int i = 0; i < 3; i++) begin
      cnt_model[i] = 0;
    end
    clear_monitor();
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Voting while the group is out of lockstep
    for (int n = 0; n < 50; n++) begin
      @(negedge clk);
      base = $urandom;
      pick = $urandom_range(3, 0);
      trip = {base, base, base};
      if (pick < 3) begin
        trip[pick] = base ^ ($urandom | 32'h1);
      end
      core_data = trip;
      exp_word  = ref_vote(trip, exp_err);
      @(posedge clk);
      check_val("voting data", exp_word, voted_data);
      check_val("voting error mask", 32'(exp_err), 32'(uut.tmr_error));
    end
    @(negedge clk);
    core_data = {good, good, good};
    end_test("voting");

    // Enter lockstep before fetch starts and then start fetching
    write_reg(tmr_pkg::TMR_ADDR_ENABLE, 32'h1);
    wait_mode("enable", tmr_pkg::TMR_RUN);
    fetch_en = 1'b1;

    inject_mismatch(1, good);
    inject_mismatch(0, good);
    inject_mismatch(2, good);
    inject_mismatch(2, good);
    inject_mismatch(1, good);
    read_counters("counter value");
    word.raw      = '0;
    word.raw[2:0] = 3'b110;
    write_reg(tmr_pkg::TMR_ADDR_CLEAR, word.raw);
    cnt_model[1] = 0;
    cnt_model[2] = 0;
    read_counters("counter after clear");
    end_test("counters");

    word.raw         = '0;
    word.cfg.setback = 1'b1;
    write_reg(tmr_pkg::TMR_ADDR_CONFIG, word.raw);
    clear_monitor();
    inject_mismatch(2, good);
    check_recovery("recovery");
    read_counters("recovery counter");
    end_test("recovery");

    word.cfg.force_resynch = 1'b1;
    clear_monitor();
    write_reg(tmr_pkg::TMR_ADDR_CONFIG, word.raw);
    wait_mode("forced unload", tmr_pkg::TMR_UNLOAD);
    wait_mode("forced return", tmr_pkg::TMR_RUN);
    check_recovery("forced");
    read_counters("forced counter");
    word.cfg.force_resynch = 1'b0;
    read_reg(tmr_pkg::TMR_ADDR_CONFIG, val);
    check_val("forced config readback", word.raw, val);
    end_test("forced resynch");

    // Leave lockstep and come back through a software synch
    clear_monitor();
    write_reg(tmr_pkg::TMR_ADDR_ENABLE, 32'h0);
    wait_mode("disable", tmr_pkg::NON_TMR);
    check_val("disable setback 110", 32'd1, 32'(sb_partial));
    check_val("disable setback 111", 32'd0, 32'(sb_full));
    word.cfg.synch_req = 1'b1;
    write_reg(tmr_pkg::TMR_ADDR_CONFIG, word.raw);
    clear_monitor();
    write_reg(tmr_pkg::TMR_ADDR_ENABLE, 32'h1);
    repeat (4) @(negedge clk);
    check_val("synch pulses", 32'd1, 32'(synch_pulses));
    check_val("waiting mode", 32'(tmr_pkg::NON_TMR), 32'(mode));
    cores_synch = 1'b1;
    wait_mode("synch reload", tmr_pkg::TMR_RELOAD);
    wait_mode("synch return", tmr_pkg::TMR_RUN);
    cores_synch = 1'b0;
    check_val("synch passed reload", 32'd1, 32'(reload_cycles > 0));
    check_val("synch pulses after return", 32'd1, 32'(synch_pulses));
    end_test("mode switch");

    prop_fails = uut.u_ctrl.u_props.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/tmr_pkg.sv
hw/tmr_regs.sv
hw/tmr_vote.sv
hw/tmr_ctrl.sv
hw/tmr_state_store.sv
hw/tmr_top.sv
test/tmr_props.sv
test/tmr_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tmr_tb -f compile.f -o tmr_sim

out=$(./obj_dir/tmr_sim +verilator+error+limit+100)
echo "$out"

echo "$out" | grep -qx "all tests passed"
